/* logic/cpuPhasePkg.sv */
`default_nettype none

package cpuPhasePkg;

	// Decoder states with one clock per phase
	typedef enum logic [2:0] {
		phaseFetch     = 3'd0,
		phaseDecode    = 3'd1,
		phaseExecute   = 3'd2,
		phaseCommit    = 3'd3,
		phaseDebugWait = 3'd4,
		phaseStopped   = 3'd5
	} phaseType;

	localparam int instrWidth = 16;

	// Register sequence opcode
	localparam int seqFieldMsb = 15;
	localparam int seqFieldLsb = 12;

	// Byte or word access
	localparam int byteFieldBit = 11;

	// Bits 10..8 reserved

	localparam int regAFieldMsb = 7;
	localparam int regAFieldLsb = 4;

	localparam int regBFieldMsb = 3;
	localparam int regBFieldLsb = 0;

endpackage

`default_nettype wire

/* logic/regSeqPkg.sv */
`default_nettype none

package regSeqPkg;

	// Register sequence opcodes where codes 6..15 act as seqNone
	typedef enum logic [3:0] {
		seqNone   = 4'd0,
		seqRdaRdb = 4'd1,
		seqLdaRdb = 4'd2,
		seqLdaUpb = 4'd3,
		seqRdaUpb = 4'd4,
		seqLdaImm = 4'd5
	} regSeqType;

	typedef enum logic {
		byteWord = 1'b0,
		byteByte = 1'b1
	} byteModeType;

	localparam int regCount = 16;
	localparam int regIdxWidth = 4;
	localparam int dataWidth = 16;

	// Width of one byte lane
	localparam int laneWidth = 8;

endpackage

`default_nettype wire

/* logic/instructionPhaseDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instructionPhaseDecoder (
	input  logic CLK,
	input  logic reset,
	input  logic [cpuPhasePkg::instrWidth-1:0] din,
	input  logic halt,
	input  logic debugStop,
	input  logic debugStepReq,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit,
	output logic pcEn,
	output logic stopped,
	output logic debugActive,
	output logic debugStepAck,
	output logic [cpuPhasePkg::instrWidth-1:0] instruction
);

	cpuPhasePkg::phaseType state;
	cpuPhasePkg::phaseType nextState;

	// Set while a single-stepped instruction is in flight
	logic stepping;

	always_comb begin
		nextState = state;
		case (state)
			cpuPhasePkg::phaseFetch: nextState = cpuPhasePkg::phaseDecode;
			cpuPhasePkg::phaseDecode: nextState = cpuPhasePkg::phaseExecute;
			cpuPhasePkg::phaseExecute: nextState = cpuPhasePkg::phaseCommit;
			cpuPhasePkg::phaseCommit: begin
				// Halt wins over debug
				if (halt) begin
					nextState = cpuPhasePkg::phaseStopped;
				end else if (debugStop) begin
					nextState = cpuPhasePkg::phaseDebugWait;
				end else begin
					nextState = cpuPhasePkg::phaseFetch;
				end
			end
			cpuPhasePkg::phaseDebugWait: begin
				if (debugStepReq || !debugStop) begin
					nextState = cpuPhasePkg::phaseFetch;
				end
			end
			// Only reset leaves stopped
			cpuPhasePkg::phaseStopped: nextState = cpuPhasePkg::phaseStopped;
			default: nextState = cpuPhasePkg::phaseFetch;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= cpuPhasePkg::phaseFetch;
		end else begin
			state <= nextState;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			stepping <= 1'b0;
		end else if (state == cpuPhasePkg::phaseDebugWait && debugStepReq) begin
			stepping <= 1'b1;
		end else if (state == cpuPhasePkg::phaseCommit) begin
			stepping <= 1'b0;
		end
	end

	// Instruction word captured at end of fetch
	always_ff @(posedge CLK) begin
		if (reset) begin
			instruction <= '0;
		end else if (state == cpuPhasePkg::phaseFetch) begin
			instruction <= din;
		end
	end

	assign fetch = state == cpuPhasePkg::phaseFetch;
	assign decode = state == cpuPhasePkg::phaseDecode;
	assign execute = state == cpuPhasePkg::phaseExecute;
	assign commit = state == cpuPhasePkg::phaseCommit;
	assign stopped = state == cpuPhasePkg::phaseStopped;
	assign debugActive = state == cpuPhasePkg::phaseDebugWait;

	assign pcEn = fetch;

	// One pulse in the commit of a stepped instruction
	assign debugStepAck = commit && stepping;

endmodule

`default_nettype wire

/* logic/registerSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module registerSequencer (
	input  logic CLK,
	input  logic reset,
	input  regSeqPkg::regSeqType seqOp,
	input  regSeqPkg::byteModeType byteMode,
	input  logic a0,
	input  logic [regSeqPkg::regIdxWidth-1:0] regAIdx,
	input  logic [regSeqPkg::regIdxWidth-1:0] regBIdx,
	input  logic decode,
	input  logic commit,
	input  logic [regSeqPkg::dataWidth-1:0] aWriteData,
	input  logic [regSeqPkg::dataWidth-1:0] bWriteData,
	output logic regAEn,
	output logic regAWen,
	output logic regBEn,
	output logic regBWen,
	output logic [regSeqPkg::regCount-1:0] aWrLo,
	output logic [regSeqPkg::regCount-1:0] aWrHi,
	output logic [regSeqPkg::regCount-1:0] bWrLo,
	output logic [regSeqPkg::regCount-1:0] bWrHi,
	output logic [regSeqPkg::dataWidth-1:0] aLaneData,
	output logic [regSeqPkg::dataWidth-1:0] bLaneData
);

	logic aRead;
	logic bRead;
	logic aWrite;
	logic bWrite;
	logic a0Latched;
	logic byteWrite;
	logic aLoLane;
	logic aHiLane;
	logic [regSeqPkg::laneWidth-1:0] aByte;
	logic [regSeqPkg::regCount-1:0] aOneHot;
	logic [regSeqPkg::regCount-1:0] bOneHot;

	// Read and write intent per opcode
	always_comb begin
		aRead = 1'b0;
		bRead = 1'b0;
		aWrite = 1'b0;
		bWrite = 1'b0;
		case (seqOp)
			regSeqPkg::seqRdaRdb: begin
				aRead = 1'b1;
				bRead = 1'b1;
			end
			regSeqPkg::seqLdaRdb: begin
				bRead = 1'b1;
				aWrite = 1'b1;
			end
			regSeqPkg::seqLdaUpb: begin
				bRead = 1'b1;
				aWrite = 1'b1;
				bWrite = 1'b1;
			end
			regSeqPkg::seqRdaUpb: begin
				aRead = 1'b1;
				bRead = 1'b1;
				bWrite = 1'b1;
			end
			regSeqPkg::seqLdaImm: aWrite = 1'b1;
			default: ;
		endcase
	end

	// Byte address held from decode
	always_ff @(posedge CLK) begin
		if (reset) begin
			a0Latched <= 1'b0;
		end else if (decode) begin
			a0Latched <= a0;
		end
	end

	assign regAEn = (decode && aRead) || (commit && aWrite);
	assign regBEn = (decode && bRead) || (commit && bWrite);
	assign regAWen = commit && aWrite;
	assign regBWen = commit && bWrite;

	assign byteWrite = byteMode == regSeqPkg::byteByte;
	assign aLoLane = regAWen && (!byteWrite || !a0Latched);
	assign aHiLane = regAWen && (!byteWrite || a0Latched);

	// Low byte steered to the addressed lane
	assign aByte = aWriteData[regSeqPkg::laneWidth-1:0];
	assign aLaneData = !byteWrite ? aWriteData :
		a0Latched ? {aByte, {regSeqPkg::laneWidth{1'b0}}} :
		{{regSeqPkg::laneWidth{1'b0}}, aByte};
	assign bLaneData = bWriteData;

	assign aOneHot = {{(regSeqPkg::regCount - 1){1'b0}}, 1'b1} << regAIdx;
	assign bOneHot = {{(regSeqPkg::regCount - 1){1'b0}}, 1'b1} << regBIdx;

	assign aWrLo = aLoLane ? aOneHot : '0;
	assign aWrHi = aHiLane ? aOneHot : '0;
	// Port B always writes the whole word
	assign bWrLo = regBWen ? bOneHot : '0;
	assign bWrHi = regBWen ? bOneHot : '0;

endmodule

`default_nettype wire

/* logic/registerSlice.sv */
`timescale 1ns/1ps
`default_nettype none

module registerSlice (
	input  logic CLK,
	input  logic reset,
	input  logic aWrLo,
	input  logic aWrHi,
	input  logic bWrLo,
	input  logic bWrHi,
	input  logic [regSeqPkg::dataWidth-1:0] aLaneData,
	input  logic [regSeqPkg::dataWidth-1:0] bLaneData,
	output logic [regSeqPkg::dataWidth-1:0] value
);

	// Port A has priority in each lane
	always_ff @(posedge CLK) begin
		if (reset) begin
			value <= '0;
		end else begin
			if (aWrLo) begin
				value[regSeqPkg::laneWidth-1:0] <= aLaneData[regSeqPkg::laneWidth-1:0];
			end else if (bWrLo) begin
				value[regSeqPkg::laneWidth-1:0] <= bLaneData[regSeqPkg::laneWidth-1:0];
			end

			if (aWrHi) begin
				value[regSeqPkg::dataWidth-1:regSeqPkg::laneWidth] <=
					aLaneData[regSeqPkg::dataWidth-1:regSeqPkg::laneWidth];
			end else if (bWrHi) begin
				value[regSeqPkg::dataWidth-1:regSeqPkg::laneWidth] <=
					bLaneData[regSeqPkg::dataWidth-1:regSeqPkg::laneWidth];
			end
		end
	end

endmodule

`default_nettype wire

/* logic/registerReadPorts.sv */
`timescale 1ns/1ps
`default_nettype none

module registerReadPorts (
	input  logic CLK,
	input  logic reset,
	input  logic [regSeqPkg::dataWidth-1:0] slices [regSeqPkg::regCount],
	input  logic [regSeqPkg::regIdxWidth-1:0] regAIdx,
	input  logic [regSeqPkg::regIdxWidth-1:0] regBIdx,
	input  logic regAEn,
	input  logic regBEn,
	input  logic decode,
	output logic [regSeqPkg::dataWidth-1:0] readA,
	output logic [regSeqPkg::dataWidth-1:0] readB
);

	logic [regSeqPkg::dataWidth-1:0] selA;
	logic [regSeqPkg::dataWidth-1:0] selB;

	assign selA = slices[regAIdx];
	assign selB = slices[regBIdx];

	// Enables are also high in commit for writes, so qualify with decode
	always_ff @(posedge CLK) begin
		if (reset) begin
			readA <= '0;
			readB <= '0;
		end else begin
			if (decode && regAEn) begin
				readA <= selA;
			end
			if (decode && regBEn) begin
				readB <= selB;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/registerSubsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module registerSubsystem (
	input  logic CLK,
	input  logic reset,
	input  logic [cpuPhasePkg::instrWidth-1:0] din,
	input  logic halt,
	input  logic debugStop,
	input  logic debugStepReq,
	input  logic a0,
	input  logic [regSeqPkg::dataWidth-1:0] aWriteData,
	input  logic [regSeqPkg::dataWidth-1:0] bWriteData,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit,
	output logic stopped,
	output logic debugActive,
	output logic debugStepAck,
	output logic pcEn,
	output logic [cpuPhasePkg::instrWidth-1:0] instruction,
	output logic [regSeqPkg::dataWidth-1:0] readA,
	output logic [regSeqPkg::dataWidth-1:0] readB
);

	regSeqPkg::regSeqType seqOp;
	regSeqPkg::byteModeType byteMode;
	logic [regSeqPkg::regIdxWidth-1:0] regAIdx;
	logic [regSeqPkg::regIdxWidth-1:0] regBIdx;
	logic regAEn;
	logic regBEn;
	logic [regSeqPkg::regCount-1:0] aWrLo;
	logic [regSeqPkg::regCount-1:0] aWrHi;
	logic [regSeqPkg::regCount-1:0] bWrLo;
	logic [regSeqPkg::regCount-1:0] bWrHi;
	logic [regSeqPkg::dataWidth-1:0] aLaneData;
	logic [regSeqPkg::dataWidth-1:0] bLaneData;
	wire  [regSeqPkg::dataWidth-1:0] sliceValues [regSeqPkg::regCount];

	// Instruction fields
	assign seqOp = regSeqPkg::regSeqType'(
		instruction[cpuPhasePkg::seqFieldMsb:cpuPhasePkg::seqFieldLsb]);
	assign byteMode = regSeqPkg::byteModeType'(instruction[cpuPhasePkg::byteFieldBit]);
	assign regAIdx = instruction[cpuPhasePkg::regAFieldMsb:cpuPhasePkg::regAFieldLsb];
	assign regBIdx = instruction[cpuPhasePkg::regBFieldMsb:cpuPhasePkg::regBFieldLsb];

	instructionPhaseDecoder u_instructionPhaseDecoder (
		.CLK(CLK),
		.reset(reset),
		.din(din),
		.halt(halt),
		.debugStop(debugStop),
		.debugStepReq(debugStepReq),
		.fetch(fetch),
		.decode(decode),
		.execute(execute),
		.commit(commit),
		.pcEn(pcEn),
		.stopped(stopped),
		.debugActive(debugActive),
		.debugStepAck(debugStepAck),
		.instruction(instruction)
	);

	registerSequencer u_registerSequencer (
		.CLK(CLK),
		.reset(reset),
		.seqOp(seqOp),
		.byteMode(byteMode),
		.a0(a0),
		.regAIdx(regAIdx),
		.regBIdx(regBIdx),
		.decode(decode),
		.commit(commit),
		.aWriteData(aWriteData),
		.bWriteData(bWriteData),
		.regAEn(regAEn),
		.regAWen(),
		.regBEn(regBEn),
		.regBWen(),
		.aWrLo(aWrLo),
		.aWrHi(aWrHi),
		.bWrLo(bWrLo),
		.bWrHi(bWrHi),
		.aLaneData(aLaneData),
		.bLaneData(bLaneData)
	);

	for (genvar i = 0; i < regSeqPkg::regCount; i++) begin : gSlice
		registerSlice u_registerSlice (
			.CLK(CLK),
			.reset(reset),
			.aWrLo(aWrLo[i]),
			.aWrHi(aWrHi[i]),
			.bWrLo(bWrLo[i]),
			.bWrHi(bWrHi[i]),
			.aLaneData(aLaneData),
			.bLaneData(bLaneData),
			.value(sliceValues[i])
		);
	end

	registerReadPorts u_registerReadPorts (
		.CLK(CLK),
		.reset(reset),
		.slices(sliceValues),
		.regAIdx(regAIdx),
		.regBIdx(regBIdx),
		.regAEn(regAEn),
		.regBEn(regBEn),
		.decode(decode),
		.readA(readA),
		.readB(readB)
	);

endmodule

`default_nettype wire

/* tests/sequenceTable.svh */
`ifndef sequenceTableSvh
`define sequenceTableSvh

// Each row is opcode, byte flag, a0, A index, B index, aWriteData, bWriteData,
// expected readA and expected readB
localparam int rowCount = 19;

localparam logic [3:0] opNone = regSeqPkg::seqNone;
localparam logic [3:0] opRdaRdb = regSeqPkg::seqRdaRdb;
localparam logic [3:0] opLdaRdb = regSeqPkg::seqLdaRdb;
localparam logic [3:0] opLdaUpb = regSeqPkg::seqLdaUpb;
localparam logic [3:0] opRdaUpb = regSeqPkg::seqRdaUpb;
localparam logic [3:0] opLdaImm = regSeqPkg::seqLdaImm;

typedef struct packed {
	logic [3:0] op;
	logic byteFlag;
	logic a0;
	logic [3:0] aIdx;
	logic [3:0] bIdx;
	logic [15:0] aData;
	logic [15:0] bData;
	logic [15:0] expA;
	logic [15:0] expB;
} seqRow;

seqRow rows [rowCount];

task automatic loadSequenceTable;
	// Word writes and their read-back
	rows[0] = {opLdaImm, 1'b0, 1'b0, 4'd1, 4'd0, 16'h1234, 16'h0000, 16'h0000, 16'h0000};
	rows[1] = {opLdaRdb, 1'b0, 1'b0, 4'd2, 4'd1, 16'h5678, 16'h0000, 16'h0000, 16'h1234};
	rows[2] = {opLdaUpb, 1'b0, 1'b0, 4'd3, 4'd4, 16'h9abc, 16'hdef0, 16'h0000, 16'h0000};
	rows[3] = {opRdaRdb, 1'b0, 1'b0, 4'd3, 4'd4, 16'h0000, 16'h0000, 16'h9abc, 16'hdef0};
	rows[4] = {opRdaRdb, 1'b1, 1'b0, 4'd1, 4'd2, 16'h0000, 16'h0000, 16'h1234, 16'h5678};
	// Byte writes to the low lane and then the high lane
	rows[5] = {opLdaRdb, 1'b1, 1'b0, 4'd1, 4'd3, 16'h00a5, 16'h0000, 16'h1234, 16'h9abc};
	rows[6] = {opLdaUpb, 1'b1, 1'b1, 4'd2, 4'd5, 16'hff3c, 16'h4321, 16'h1234, 16'h0000};
	rows[7] = {opRdaRdb, 1'b0, 1'b0, 4'd1, 4'd2, 16'h0000, 16'h0000, 16'h12a5, 16'h3c78};
	rows[8] = {opRdaRdb, 1'b1, 1'b1, 4'd5, 4'd3, 16'h0000, 16'h0000, 16'h4321, 16'h9abc};
	// Only B changes and then nothing changes
	rows[9] = {opRdaUpb, 1'b0, 1'b0, 4'd6, 4'd1, 16'hffff, 16'h0bad, 16'h0000, 16'h12a5};
	rows[10] = {opNone, 1'b0, 1'b0, 4'd1, 4'd6, 16'h1111, 16'h2222, 16'h0000, 16'h12a5};
	rows[11] = {opRdaRdb, 1'b0, 1'b0, 4'd6, 4'd1, 16'h0000, 16'h0000, 16'h0000, 16'h0bad};
	// Same register on both ports
	rows[12] = {opLdaUpb, 1'b0, 1'b0, 4'd7, 4'd7, 16'haaaa, 16'h5555, 16'h0000, 16'h0000};
	rows[13] = {opLdaUpb, 1'b1, 1'b0, 4'd8, 4'd8, 16'h0077, 16'h1234, 16'h0000, 16'h0000};
	rows[14] = {opRdaRdb, 1'b0, 1'b0, 4'd7, 4'd8, 16'h0000, 16'h0000, 16'haaaa, 16'h1277};
	rows[15] = {opLdaUpb, 1'b1, 1'b1, 4'd9, 4'd9, 16'h00c3, 16'h5a5a, 16'haaaa, 16'h0000};
	rows[16] = {opRdaRdb, 1'b0, 1'b0, 4'd9, 4'd0, 16'h0000, 16'h0000, 16'hc35a, 16'h0000};
	// Unused code acts as seqNone
	rows[17] = {4'hf, 1'b0, 1'b0, 4'd9, 4'd7, 16'hffff, 16'hffff, 16'hc35a, 16'h0000};
	rows[18] = {opRdaRdb, 1'b0, 1'b0, 4'd9, 4'd7, 16'h0000, 16'h0000, 16'hc35a, 16'haaaa};
endtask

`endif

/* tests/registerSubsystemTests.sv */
`timescale 1ns/1ps
`default_nettype none

module registerSubsystemTests;

	localparam int clockPeriod = 10;
	localparam int debugHaltCycles = 100;

	logic CLK;
	logic reset;
	logic [15:0] din;
	logic halt;
	logic debugStop;
	logic debugStepReq;
	logic a0;
	logic [15:0] aWriteData;
	logic [15:0] bWriteData;
	logic fetch;
	logic decode;
	logic execute;
	logic commit;
	logic stopped;
	logic debugActive;
	logic debugStepAck;
	logic pcEn;
	logic [15:0] instruction;
	logic [15:0] readA;
	logic [15:0] readB;

	int errorCount;
	int passCount;
	int failCount;
	integer seed;
	logic [15:0] shadow [16];

	`include "sequenceTable.svh"

	// One instruction is four clocks
	localparam int instrCount = 1 + rowCount + 3 * regSeqPkg::regCount;
	localparam int watchdogCycles = 2 * instrCount * 4 + debugHaltCycles;

	registerSubsystem u_registerSubsystem (
		.CLK(CLK),
		.reset(reset),
		.din(din),
		.halt(halt),
		.debugStop(debugStop),
		.debugStepReq(debugStepReq),
		.a0(a0),
		.aWriteData(aWriteData),
		.bWriteData(bWriteData),
		.fetch(fetch),
		.decode(decode),
		.execute(execute),
		.commit(commit),
		.stopped(stopped),
		.debugActive(debugActive),
		.debugStepAck(debugStepAck),
		.pcEn(pcEn),
		.instruction(instruction),
		.readA(readA),
		.readB(readB)
	);

	initial begin
		CLK = 1'b0;
		forever #(clockPeriod / 2) CLK = ~CLK;
	end

	initial begin
		repeat (watchdogCycles) @(posedge CLK);
		$display("Timeout: the run did not finish within %0d clock cycles", watchdogCycles);
		$display("Something failed");
		$finish;
	end

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			errorCount++;
			$display("Mismatch %s: expected 0x%0h, got 0x%0h", name, expected, actual);
		end
	endtask

	task automatic finishTest(input string name, input int errorsAtStart);
		if (errorCount == errorsAtStart) begin
			passCount++;
			$display("%s: passed", name);
		end else begin
			failCount++;
			$display("%s: failed with %0d mismatches", name, errorCount - errorsAtStart);
		end
	endtask

	task automatic waitFetch;
		while (!fetch) @(negedge CLK);
	endtask

	// Drives one instruction from fetch and returns the operands seen in execute
	task automatic runInstr(input logic [3:0] op, input logic byteFlag, input logic a0Value,
			input logic [3:0] aIdx, input logic [3:0] bIdx, input logic [15:0] aData,
			input logic [15:0] bData, output logic [15:0] gotA, output logic [15:0] gotB);
		waitFetch();
		din = {op, byteFlag, 3'b000, aIdx, bIdx};
		a0 = a0Value;
		aWriteData = aData;
		bWriteData = bData;
		@(negedge CLK);
		checkValue("decode", 1, decode);
		@(negedge CLK);
		checkValue("execute", 1, execute);
		gotA = readA;
		gotB = readB;
		@(negedge CLK);
		checkValue("commit", 1, commit);
	endtask

	task automatic applyWrite(input logic [3:0] op, input logic byteFlag, input logic a0Value,
			input logic [3:0] aIdx, input logic [3:0] bIdx, input logic [15:0] aData,
			input logic [15:0] bData);
		logic aWrites;
		logic bWrites;
		aWrites = op == opLdaRdb || op == opLdaUpb || op == opLdaImm;
		bWrites = op == opLdaUpb || op == opRdaUpb;
		// B first so that A overrides the lanes it writes
		if (bWrites) begin
			shadow[bIdx] = bData;
		end
		if (aWrites) begin
			if (!byteFlag) begin
				shadow[aIdx] = aData;
			end else if (a0Value) begin
				shadow[aIdx][15:8] = aData[7:0];
			end else begin
				shadow[aIdx][7:0] = aData[7:0];
			end
		end
	endtask

	task automatic checkPhaseRotation;
		int start;
		start = errorCount;
		// State right after reset
		checkValue("stopped", 0, stopped);
		checkValue("debugActive", 0, debugActive);
		checkValue("debugStepAck", 0, debugStepAck);
		checkValue("readA", 0, readA);
		checkValue("readB", 0, readB);
		din = 16'h0c3a;
		checkValue("phases in fetch", 4'b1000, {fetch, decode, execute, commit});
		checkValue("pcEn in fetch", 1, pcEn);
		@(negedge CLK);
		checkValue("phases in decode", 4'b0100, {fetch, decode, execute, commit});
		checkValue("pcEn in decode", 0, pcEn);
		checkValue("instruction", 16'h0c3a, instruction);
		@(negedge CLK);
		checkValue("phases in execute", 4'b0010, {fetch, decode, execute, commit});
		@(negedge CLK);
		checkValue("phases in commit", 4'b0001, {fetch, decode, execute, commit});
		checkValue("instruction held", 16'h0c3a, instruction);
		@(negedge CLK);
		checkValue("phases in next fetch", 4'b1000, {fetch, decode, execute, commit});
		checkValue("pcEn in next fetch", 1, pcEn);
		finishTest("Phase rotation", start);
	endtask

	task automatic runSequenceTable;
		int start;
		logic [15:0] gotA;
		logic [15:0] gotB;
		start = errorCount;
		for (int r = 0; r < rowCount; r++) begin
			runInstr(rows[r].op, rows[r].byteFlag, rows[r].a0, rows[r].aIdx, rows[r].bIdx,
				rows[r].aData, rows[r].bData, gotA, gotB);
			checkValue($sformatf("readA row %0d", r), rows[r].expA, gotA);
			checkValue($sformatf("readB row %0d", r), rows[r].expB, gotB);
		end
		finishTest("Sequence table", start);
	endtask

	task automatic runRandomReadBack;
		int start;
		logic [31:0] pick;
		logic [15:0] aData;
		logic [15:0] bData;
		logic [15:0] gotA;
		logic [15:0] gotB;
		start = errorCount;
		for (int i = 0; i < 16; i++) begin
			aData = $random(seed);
			runInstr(opLdaImm, 1'b0, 1'b0, i[3:0], 4'd0, aData, 16'h0000, gotA, gotB);
			applyWrite(opLdaImm, 1'b0, 1'b0, i[3:0], 4'd0, aData, 16'h0000);
		end
		// Mixed byte and word updates on both ports
		for (int i = 0; i < 16; i++) begin
			pick = $random(seed);
			aData = $random(seed);
			bData = $random(seed);
			runInstr(opLdaUpb, pick[0], pick[1], pick[7:4], pick[11:8], aData, bData, gotA, gotB);
			checkValue($sformatf("readB update %0d", i), shadow[pick[11:8]], gotB);
			applyWrite(opLdaUpb, pick[0], pick[1], pick[7:4], pick[11:8], aData, bData);
		end
		for (int i = 0; i < 16; i++) begin
			runInstr(opRdaRdb, 1'b0, 1'b0, i[3:0], ~i[3:0], 16'h0000, 16'h0000, gotA, gotB);
			checkValue($sformatf("readA r%0d", i), shadow[i[3:0]], gotA);
			checkValue($sformatf("readB r%0d", 15 - i), shadow[~i[3:0]], gotB);
		end
		finishTest("Random read-back", start);
	endtask

	task automatic exerciseDebugStep;
		int start;
		int fetchCount;
		int commitCount;
		int ackCount;
		int strayAck;
		int cycles;
		start = errorCount;
		waitFetch();
		din = 16'h0000;
		debugStop = 1'b1;
		repeat (3) @(negedge CLK);
		checkValue("commit before debug wait", 1, commit);
		@(negedge CLK);
		repeat (4) begin
			checkValue("debugActive", 1, debugActive);
			checkValue("phases in debug wait", 0, {fetch, decode, execute, commit});
			@(negedge CLK);
		end
		repeat (2) begin
			debugStepReq = 1'b1;
			@(negedge CLK);
			debugStepReq = 1'b0;
			fetchCount = 0;
			commitCount = 0;
			ackCount = 0;
			strayAck = 0;
			cycles = 0;
			while (!debugActive && cycles < 10) begin
				fetchCount += fetch;
				commitCount += commit;
				ackCount += debugStepAck;
				if (debugStepAck && !commit) begin
					strayAck++;
				end
				@(negedge CLK);
				cycles++;
			end
			checkValue("fetches per step", 1, fetchCount);
			checkValue("commits per step", 1, commitCount);
			checkValue("debugStepAck per step", 1, ackCount);
			checkValue("debugStepAck outside commit", 0, strayAck);
			checkValue("debugActive after step", 1, debugActive);
		end
		// Free running again
		debugStop = 1'b0;
		@(negedge CLK);
		fetchCount = 0;
		ackCount = 0;
		repeat (8) begin
			checkValue("debugActive after resume", 0, debugActive);
			fetchCount += fetch;
			ackCount += debugStepAck;
			@(negedge CLK);
		end
		checkValue("fetches after resume", 2, fetchCount);
		checkValue("debugStepAck after resume", 0, ackCount);
		finishTest("Debug step", start);
	endtask

	task automatic exerciseHalt;
		int start;
		start = errorCount;
		waitFetch();
		din = 16'h0000;
		halt = 1'b1;
		repeat (3) @(negedge CLK);
		checkValue("commit before halt", 1, commit);
		@(negedge CLK);
		halt = 1'b0;
		repeat (8) begin
			checkValue("stopped", 1, stopped);
			checkValue("fetch while stopped", 0, fetch);
			@(negedge CLK);
		end
		reset = 1'b1;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		reset = 1'b0;
		checkValue("stopped after reset", 0, stopped);
		checkValue("fetch after reset", 1, fetch);
		checkValue("readA after reset", 0, readA);
		checkValue("readB after reset", 0, readB);
		finishTest("Halt", start);
	endtask

	initial begin
		reset = 1'b1;
		din = '0;
		halt = 1'b0;
		debugStop = 1'b0;
		debugStepReq = 1'b0;
		a0 = 1'b0;
		aWriteData = '0;
		bWriteData = '0;
		errorCount = 0;
		passCount = 0;
		failCount = 0;
		seed = 32'ha1ce;
		loadSequenceTable();
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		reset = 1'b0;

		checkPhaseRotation();
		runSequenceTable();
		runRandomReadBack();
		exerciseDebugStep();
		exerciseHalt();

		$display("Summary: %0d tests passed, %0d tests failed, %0d mismatches",
			passCount, failCount, errorCount);
		if (errorCount == 0 && failCount == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+tests
logic/cpuPhasePkg.sv
logic/regSeqPkg.sv
logic/instructionPhaseDecoder.sv
logic/registerSequencer.sv
logic/registerSlice.sv
logic/registerReadPorts.sv
logic/registerSubsystem.sv
tests/registerSubsystemTests.sv
